/* rtl/ntt_defines_pkg.sv */
`default_nettype none

package ntt_defines_pkg;

    // ======================================================================
    // Coefficient arithmetic
    // ======================================================================

    localparam int COEFF_W = 23;

    // q = 2^23 - 2^13 + 1
    localparam logic [COEFF_W-1:0] DILITHIUM_Q = 23'd8380417;

    // Packed field per coefficient, top bit always zero
    localparam int LANE_W = 24;

    // ======================================================================
    // Memory layout
    // ======================================================================

    // Four coefficients per word
    localparam int MEM_DATA_W = 4 * LANE_W;
    localparam int MEM_ADDR_W = 15;

    // 256 coefficients per polynomial
    localparam int WORDS_PER_POLY = 64;
    localparam int WORD_CNT_W = 6;

    // ======================================================================
    // Pipeline
    // ======================================================================

    // Cycles through the lanes, counting the output flop in the top
    localparam int PWO_LATENCY = 3;

    // Read strobe to write strobe
    // Memory read, input flop, then the lanes
    localparam int RD_TO_WR_DELAY = PWO_LATENCY + 2;

    typedef enum logic [1:0] {
        MODE_PWM = 2'd0,
        MODE_PWA = 2'd1,
        MODE_PWS = 2'd2
    } pwo_mode_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ISSUE = 2'd1,
        ST_DRAIN = 2'd2
    } ctrl_state_e;

endpackage

`default_nettype wire

/* rtl/pwo_mod_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module pwo_mod_mult (
    input  wire                                 clk,
    input  wire                                 reset_n,
    input  wire                                 zeroize_i,
    input  wire [ntt_defines_pkg::COEFF_W-1:0]  a_i,
    input  wire [ntt_defines_pkg::COEFF_W-1:0]  b_i,
    output logic [ntt_defines_pkg::COEFF_W-1:0] p_o
);
    import ntt_defines_pkg::*;

    logic [2*COEFF_W-1:0] prod_q;
    logic [COEFF_W-1:0]   prod_lo;
    logic [COEFF_W-1:0]   prod_hi;
    logic [COEFF_W+3:0]   fold_s;
    logic [COEFF_W:0]     fold_t;
    logic [COEFF_W:0]     fold_sub;
    logic [COEFF_W-1:0]   p_d;

    assign prod_lo = prod_q[COEFF_W-1:0];
    assign prod_hi = prod_q[2*COEFF_W-1:COEFF_W];

    // First fold, using 2^23 = 2^13 - 1 mod q
    // hi * 2^13 splits again at bit 10 so its upper part folds the same way
    // 2q keeps the sum positive
    assign fold_s = {4'b0, prod_lo}
                  + {4'b0, prod_hi[9:0], 13'b0}
                  + {1'b0, prod_hi[22:10], 13'b0}
                  + {3'b0, DILITHIUM_Q, 1'b0}
                  - {4'b0, prod_hi}
                  - {14'b0, prod_hi[22:10]};

    // Second fold of the four carry bits, lands below 2q
    assign fold_t = {1'b0, fold_s[22:0]}
                  + {7'b0, fold_s[26:23], 13'b0}
                  - {20'b0, fold_s[26:23]};

    assign fold_sub = fold_t - {1'b0, DILITHIUM_Q};

    // Borrow means already below q
    assign p_d = fold_sub[COEFF_W] ? fold_t[COEFF_W-1:0] : fold_sub[COEFF_W-1:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
            p_o    <= '0;
        end else if (zeroize_i) begin
            prod_q <= '0;
            p_o    <= '0;
        end else begin
            prod_q <= a_i * b_i;
            p_o    <= p_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/pwo_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module pwo_lane (
    input  wire                                 clk,
    input  wire                                 reset_n,
    input  wire                                 zeroize_i,
    input  wire ntt_defines_pkg::pwo_mode_e     mode_i,
    input  wire                                 accumulate_i,
    input  wire [ntt_defines_pkg::COEFF_W-1:0]  u_i,
    input  wire [ntt_defines_pkg::COEFF_W-1:0]  v_i,
    input  wire [ntt_defines_pkg::COEFF_W-1:0]  w_i,
    output logic [ntt_defines_pkg::COEFF_W-1:0] r_o
);
    import ntt_defines_pkg::*;

    // Sum of two values below q, one correction
    function automatic logic [COEFF_W-1:0] mod_add(input logic [COEFF_W-1:0] x,
                                                   input logic [COEFF_W-1:0] y);
        logic [COEFF_W:0] sum;
        logic [COEFF_W:0] red;
        sum = {1'b0, x} + {1'b0, y};
        red = sum - {1'b0, DILITHIUM_Q};
        return (sum >= {1'b0, DILITHIUM_Q}) ? red[COEFF_W-1:0] : sum[COEFF_W-1:0];
    endfunction

    logic [COEFF_W-1:0] prod;
    logic [COEFF_W:0]   diff;
    logic [COEFF_W:0]   diff_fix;
    logic [COEFF_W-1:0] as_d;
    logic [COEFF_W-1:0] as_q1;
    logic [COEFF_W-1:0] as_q2;
    logic [COEFF_W-1:0] w_q1;
    logic [COEFF_W-1:0] w_q2;

    pwo_mod_mult mult_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (u_i),
        .b_i       (v_i),
        .p_o       (prod)
    );

    // Borrow out of u - v adds q back
    assign diff     = {1'b0, u_i} - {1'b0, v_i};
    assign diff_fix = diff + {1'b0, DILITHIUM_Q};

    assign as_d = (mode_i == MODE_PWS)
                ? (diff[COEFF_W] ? diff_fix[COEFF_W-1:0] : diff[COEFF_W-1:0])
                : mod_add(u_i, v_i);

    // Add/sub result and old c both wait out the multiplier
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            as_q1 <= '0;
            as_q2 <= '0;
            w_q1  <= '0;
            w_q2  <= '0;
        end else if (zeroize_i) begin
            as_q1 <= '0;
            as_q2 <= '0;
            w_q1  <= '0;
            w_q2  <= '0;
        end else begin
            as_q1 <= as_d;
            as_q2 <= as_q1;
            w_q1  <= accumulate_i ? w_i : '0;
            w_q2  <= w_q1;
        end
    end

    // Final accumulate feeds the output flop in the top
    assign r_o = (mode_i == MODE_PWM) ? mod_add(prod, w_q2) : as_q2;

endmodule

`default_nettype wire

/* rtl/pwo_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pwo_unit (
    input  wire                                   clk,
    input  wire                                   reset_n,
    input  wire                                   zeroize_i,
    input  wire ntt_defines_pkg::pwo_mode_e       mode_i,
    input  wire                                   accumulate_i,
    input  wire                                   enable_i,
    input  wire [ntt_defines_pkg::MEM_DATA_W-1:0] a_i,
    input  wire [ntt_defines_pkg::MEM_DATA_W-1:0] b_i,
    input  wire [ntt_defines_pkg::MEM_DATA_W-1:0] c_i,
    output wire [ntt_defines_pkg::MEM_DATA_W-1:0] result_o,
    output logic                                  valid_o
);
    import ntt_defines_pkg::*;

    logic [PWO_LATENCY-1:0] en_pipe_q;

    // One lane per packed field, zero top bit dropped and restored
    for (genvar g = 0; g < MEM_DATA_W / LANE_W; g++) begin : g_lane
        logic [COEFF_W-1:0] r;

        pwo_lane lane_i (
            .clk          (clk),
            .reset_n      (reset_n),
            .zeroize_i    (zeroize_i),
            .mode_i       (mode_i),
            .accumulate_i (accumulate_i),
            .u_i          (a_i[g*LANE_W +: COEFF_W]),
            .v_i          (b_i[g*LANE_W +: COEFF_W]),
            .w_i          (c_i[g*LANE_W +: COEFF_W]),
            .r_o          (r)
        );

        assign result_o[g*LANE_W +: LANE_W] = {1'b0, r};
    end

    // Valid lines up with the result once the top has flopped it
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            en_pipe_q <= '0;
        end else if (zeroize_i) begin
            en_pipe_q <= '0;
        end else begin
            en_pipe_q <= {en_pipe_q[PWO_LATENCY-2:0], enable_i};
        end
    end

    assign valid_o = en_pipe_q[PWO_LATENCY-1];

endmodule

`default_nettype wire

/* rtl/ntt_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ntt_ctrl (
    input  wire                                   clk,
    input  wire                                   reset_n,
    input  wire                                   zeroize_i,
    input  wire ntt_defines_pkg::pwo_mode_e       mode_i,
    input  wire                                   ntt_enable_i,
    input  wire                                   accumulate_i,
    input  wire                                   sampler_valid_i,
    input  wire [ntt_defines_pkg::MEM_ADDR_W-1:0] base_a_i,
    input  wire [ntt_defines_pkg::MEM_ADDR_W-1:0] base_b_i,
    input  wire [ntt_defines_pkg::MEM_ADDR_W-1:0] base_c_i,
    output logic                                  rd_en_o,
    output logic                                  rd_c_en_o,
    output logic [ntt_defines_pkg::MEM_ADDR_W-1:0] rd_addr_a_o,
    output logic [ntt_defines_pkg::MEM_ADDR_W-1:0] rd_addr_b_o,
    output logic [ntt_defines_pkg::MEM_ADDR_W-1:0] rd_addr_c_o,
    output logic                                  wr_en_o,
    output logic [ntt_defines_pkg::MEM_ADDR_W-1:0] wr_addr_o,
    output ntt_defines_pkg::pwo_mode_e            run_mode_o,
    output logic                                  run_acc_o,
    output logic                                  done_o
);
    import ntt_defines_pkg::*;

    ctrl_state_e           state_q;
    logic [WORD_CNT_W-1:0] word_cnt_q;
    logic [MEM_ADDR_W-1:0] base_a_q;
    logic [MEM_ADDR_W-1:0] base_b_q;
    logic [MEM_ADDR_W-1:0] base_c_q;
    logic [MEM_ADDR_W-1:0] word_offset;
    logic                  last_word;
    logic                  last_write;

    // Write strobe and address delay line
    logic [RD_TO_WR_DELAY-1:0] wr_en_pipe_q;
    logic [MEM_ADDR_W-1:0]     wr_addr_pipe_q [RD_TO_WR_DELAY];

    // ======================================================================
    // Read issue
    // ======================================================================

    assign word_offset = MEM_ADDR_W'(word_cnt_q);

    // No reads while the sampler holds back operand b
    assign rd_en_o   = (state_q == ST_ISSUE) && sampler_valid_i;
    assign rd_c_en_o = rd_en_o && run_acc_o && (run_mode_o == MODE_PWM);

    assign rd_addr_a_o = base_a_q + word_offset;
    assign rd_addr_b_o = base_b_q + word_offset;
    assign rd_addr_c_o = base_c_q + word_offset;

    assign last_word = (word_cnt_q == WORD_CNT_W'(WORDS_PER_POLY - 1));

    // Final write leaves the delay line with nothing behind it
    assign last_write = (state_q == ST_DRAIN) && wr_en_pipe_q[RD_TO_WR_DELAY-1]
                        && (wr_en_pipe_q[RD_TO_WR_DELAY-2:0] == '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= ST_IDLE;
            word_cnt_q <= '0;
            base_a_q   <= '0;
            base_b_q   <= '0;
            base_c_q   <= '0;
            run_mode_o <= MODE_PWM;
            run_acc_o  <= 1'b0;
            done_o     <= 1'b0;
        end else if (zeroize_i) begin
            state_q    <= ST_IDLE;
            word_cnt_q <= '0;
            base_a_q   <= '0;
            base_b_q   <= '0;
            base_c_q   <= '0;
            run_mode_o <= MODE_PWM;
            run_acc_o  <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    // Run settings held until the next start
                    if (ntt_enable_i) begin
                        base_a_q   <= base_a_i;
                        base_b_q   <= base_b_i;
                        base_c_q   <= base_c_i;
                        run_mode_o <= mode_i;
                        run_acc_o  <= accumulate_i;
                        word_cnt_q <= '0;
                        state_q    <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (rd_en_o) begin
                        word_cnt_q <= word_cnt_q + 1'b1;
                        if (last_word) begin
                            state_q <= ST_DRAIN;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (last_write) begin
                        done_o  <= 1'b1;
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // ======================================================================
    // Write alignment
    // ======================================================================

    assign wr_en_o   = wr_en_pipe_q[RD_TO_WR_DELAY-1];
    assign wr_addr_o = wr_addr_pipe_q[RD_TO_WR_DELAY-1];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_en_pipe_q <= '0;
            for (int i = 0; i < RD_TO_WR_DELAY; i++) begin
                wr_addr_pipe_q[i] <= '0;
            end
        end else if (zeroize_i) begin
            wr_en_pipe_q <= '0;
            for (int i = 0; i < RD_TO_WR_DELAY; i++) begin
                wr_addr_pipe_q[i] <= '0;
            end
        end else begin
            wr_en_pipe_q      <= {wr_en_pipe_q[RD_TO_WR_DELAY-2:0], rd_en_o};
            // Result goes back to the c word just read
            wr_addr_pipe_q[0] <= rd_addr_c_o;
            for (int i = 1; i < RD_TO_WR_DELAY; i++) begin
                wr_addr_pipe_q[i] <= wr_addr_pipe_q[i-1];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/ntt_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ntt_top (
    input  wire                                    clk,
    input  wire                                    reset_n,
    input  wire                                    zeroize_i,

    // Run control
    input  wire ntt_defines_pkg::pwo_mode_e        mode_i,
    input  wire                                    ntt_enable_i,
    input  wire                                    accumulate_i,
    input  wire                                    sampler_valid_i,
    input  wire [ntt_defines_pkg::MEM_ADDR_W-1:0]  base_a_i,
    input  wire [ntt_defines_pkg::MEM_ADDR_W-1:0]  base_b_i,
    input  wire [ntt_defines_pkg::MEM_ADDR_W-1:0]  base_c_i,

    // Operand a and b read ports
    output logic                                   pwm_a_rd_en_o,
    output logic [ntt_defines_pkg::MEM_ADDR_W-1:0] pwm_a_rd_addr_o,
    input  wire [ntt_defines_pkg::MEM_DATA_W-1:0]  pwm_a_rd_data_i,
    output logic                                   pwm_b_rd_en_o,
    output logic [ntt_defines_pkg::MEM_ADDR_W-1:0] pwm_b_rd_addr_o,
    input  wire [ntt_defines_pkg::MEM_DATA_W-1:0]  pwm_b_rd_data_i,

    // Shared c memory
    output logic                                   mem_rd_en_o,
    output logic [ntt_defines_pkg::MEM_ADDR_W-1:0] mem_rd_addr_o,
    input  wire [ntt_defines_pkg::MEM_DATA_W-1:0]  mem_rd_data_i,
    output logic                                   mem_wr_en_o,
    output logic [ntt_defines_pkg::MEM_ADDR_W-1:0] mem_wr_addr_o,
    output logic [ntt_defines_pkg::MEM_DATA_W-1:0] mem_wr_data_o,

    output logic                                   ntt_done_o
);
    import ntt_defines_pkg::*;

    logic                  rd_en;
    logic                  rd_c_en;
    logic                  wr_en;
    logic [MEM_ADDR_W-1:0] rd_addr_a;
    logic [MEM_ADDR_W-1:0] rd_addr_b;
    logic [MEM_ADDR_W-1:0] rd_addr_c;
    logic [MEM_ADDR_W-1:0] wr_addr;
    pwo_mode_e             run_mode;
    logic                  run_acc;
    logic                  acc_mult;

    // Input alignment
    logic                  rd_en_q;
    logic                  unit_en_q;
    logic [MEM_DATA_W-1:0] a_q;
    logic [MEM_DATA_W-1:0] b_q;
    logic [MEM_DATA_W-1:0] c_q;
    logic [MEM_DATA_W-1:0] unit_result;

    ntt_ctrl ctrl_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize_i),
        .mode_i          (mode_i),
        .ntt_enable_i    (ntt_enable_i),
        .accumulate_i    (accumulate_i),
        .sampler_valid_i (sampler_valid_i),
        .base_a_i        (base_a_i),
        .base_b_i        (base_b_i),
        .base_c_i        (base_c_i),
        .rd_en_o         (rd_en),
        .rd_c_en_o       (rd_c_en),
        .rd_addr_a_o     (rd_addr_a),
        .rd_addr_b_o     (rd_addr_b),
        .rd_addr_c_o     (rd_addr_c),
        .wr_en_o         (wr_en),
        .wr_addr_o       (wr_addr),
        .run_mode_o      (run_mode),
        .run_acc_o       (run_acc),
        .done_o          (ntt_done_o)
    );

    // ======================================================================
    // Memory ports
    // ======================================================================

    assign pwm_a_rd_en_o   = rd_en;
    assign pwm_a_rd_addr_o = rd_addr_a;
    assign pwm_b_rd_en_o   = rd_en;
    assign pwm_b_rd_addr_o = rd_addr_b;
    assign mem_rd_en_o     = rd_c_en;
    assign mem_rd_addr_o   = rd_addr_c;
    assign mem_wr_en_o     = wr_en;
    assign mem_wr_addr_o   = wr_addr;

    // Old c only matters for an accumulating multiply
    assign acc_mult = run_acc && (run_mode == MODE_PWM);

    // ======================================================================
    // Datapath flops
    // ======================================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_en_q       <= 1'b0;
            unit_en_q     <= 1'b0;
            a_q           <= '0;
            b_q           <= '0;
            c_q           <= '0;
            mem_wr_data_o <= '0;
        end else if (zeroize_i) begin
            rd_en_q       <= 1'b0;
            unit_en_q     <= 1'b0;
            a_q           <= '0;
            b_q           <= '0;
            c_q           <= '0;
            mem_wr_data_o <= '0;
        end else begin
            // Strobe follows the memory's one cycle of latency
            rd_en_q       <= rd_en;
            unit_en_q     <= rd_en_q;
            a_q           <= pwm_a_rd_data_i;
            b_q           <= pwm_b_rd_data_i;
            c_q           <= acc_mult ? mem_rd_data_i : '0;
            mem_wr_data_o <= unit_result;
        end
    end

    pwo_unit unit_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (run_mode),
        .accumulate_i (run_acc),
        .enable_i     (unit_en_q),
        .a_i          (a_q),
        .b_i          (b_q),
        .c_i          (c_q),
        .result_o     (unit_result),
        .valid_o      ()
    );

endmodule

`default_nettype wire

/* testbench/pwo_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module pwo_mem_model (
    input  wire                                    clk,
    input  wire                                    reset_n,
    input  wire                                    rd_en_i,
    input  wire [ntt_defines_pkg::MEM_ADDR_W-1:0]  rd_addr_i,
    output logic [ntt_defines_pkg::MEM_DATA_W-1:0] rd_data_o,
    input  wire                                    wr_en_i,
    input  wire [ntt_defines_pkg::MEM_ADDR_W-1:0]  wr_addr_i,
    input  wire [ntt_defines_pkg::MEM_DATA_W-1:0]  wr_data_i
);
    import ntt_defines_pkg::*;

    // Full address space, one word per address
    logic [MEM_DATA_W-1:0] mem [2**MEM_ADDR_W];

    // Read data follows the strobe by one cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

    // Preload and DUT writes share this port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

/* testbench/ntt_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ntt_top_tb;
    import ntt_defines_pkg::*;

    localparam int CLK_HALF = 4;
    localparam int LANES = MEM_DATA_W / LANE_W;
    // Seven runs of 64 load cycles plus up to ~110 run cycles each
    localparam int TIMEOUT_CYCLES = 2000;
    // Start cycle, 64 issue cycles, five cycles from read to write, done cycle
    // Read to write is memory 1, input flop 1, lanes with output flop 3
    localparam int RUN_CYCLES = 1 + WORDS_PER_POLY + 1 + 1 + 3 + 1;
    localparam logic [COEFF_W-1:0] Q_MAX = DILITHIUM_Q - COEFF_W'(1);

    logic clk = 1'b0;
    logic reset_n;
    logic zeroize;
    pwo_mode_e mode;
    logic ntt_enable;
    logic accumulate;
    logic sampler_valid;
    logic [MEM_ADDR_W-1:0] base_a;
    logic [MEM_ADDR_W-1:0] base_b;
    logic [MEM_ADDR_W-1:0] base_c;

    wire                  a_rd_en;
    wire [MEM_ADDR_W-1:0] a_rd_addr;
    wire [MEM_DATA_W-1:0] a_rd_data;
    wire                  b_rd_en;
    wire [MEM_ADDR_W-1:0] b_rd_addr;
    wire [MEM_DATA_W-1:0] b_rd_data;
    wire                  c_rd_en;
    wire [MEM_ADDR_W-1:0] c_rd_addr;
    wire [MEM_DATA_W-1:0] c_rd_data;
    wire                  wr_en;
    wire [MEM_ADDR_W-1:0] wr_addr;
    wire [MEM_DATA_W-1:0] wr_data;
    wire                  done;

    // Preload port shared with the DUT on the c memory
    logic                  ld_en;
    logic [MEM_ADDR_W-1:0] ld_addr_a;
    logic [MEM_ADDR_W-1:0] ld_addr_b;
    logic [MEM_ADDR_W-1:0] ld_addr_c;
    logic [MEM_DATA_W-1:0] ld_data_a;
    logic [MEM_DATA_W-1:0] ld_data_b;
    logic [MEM_DATA_W-1:0] ld_data_c;
    wire                   c_wr_en;
    wire [MEM_ADDR_W-1:0]  c_wr_addr;
    wire [MEM_DATA_W-1:0]  c_wr_data;

    // Reference and run state
    integer                seed = 32'h1c8a;
    logic [MEM_DATA_W-1:0] exp_mem [WORDS_PER_POLY];
    logic [MEM_ADDR_W-1:0] run_base_c;
    logic                  stall_run;
    logic                  acc_mult_run;
    int                    cycle_cnt = 0;
    bit                    started = 1'b0;
    bit                    run_active = 1'b0;
    bit                    done_seen = 1'b0;
    bit                    written [WORDS_PER_POLY];
    int                    wr_count = 0;
    int                    start_cycle = 0;
    int                    last_wr_cycle = 0;

    assign c_wr_en   = ld_en | wr_en;
    assign c_wr_addr = ld_en ? ld_addr_c : wr_addr;
    assign c_wr_data = ld_en ? ld_data_c : wr_data;

    ntt_top dut_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize),
        .mode_i          (mode),
        .ntt_enable_i    (ntt_enable),
        .accumulate_i    (accumulate),
        .sampler_valid_i (sampler_valid),
        .base_a_i        (base_a),
        .base_b_i        (base_b),
        .base_c_i        (base_c),
        .pwm_a_rd_en_o   (a_rd_en),
        .pwm_a_rd_addr_o (a_rd_addr),
        .pwm_a_rd_data_i (a_rd_data),
        .pwm_b_rd_en_o   (b_rd_en),
        .pwm_b_rd_addr_o (b_rd_addr),
        .pwm_b_rd_data_i (b_rd_data),
        .mem_rd_en_o     (c_rd_en),
        .mem_rd_addr_o   (c_rd_addr),
        .mem_rd_data_i   (c_rd_data),
        .mem_wr_en_o     (wr_en),
        .mem_wr_addr_o   (wr_addr),
        .mem_wr_data_o   (wr_data),
        .ntt_done_o      (done)
    );

    pwo_mem_model a_mem_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .rd_en_i   (a_rd_en),
        .rd_addr_i (a_rd_addr),
        .rd_data_o (a_rd_data),
        .wr_en_i   (ld_en),
        .wr_addr_i (ld_addr_a),
        .wr_data_i (ld_data_a)
    );

    pwo_mem_model b_mem_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .rd_en_i   (b_rd_en),
        .rd_addr_i (b_rd_addr),
        .rd_data_o (b_rd_data),
        .wr_en_i   (ld_en),
        .wr_addr_i (ld_addr_b),
        .wr_data_i (ld_data_b)
    );

    pwo_mem_model c_mem_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .rd_en_i   (c_rd_en),
        .rd_addr_i (c_rd_addr),
        .rd_data_o (c_rd_data),
        .wr_en_i   (c_wr_en),
        .wr_addr_i (c_wr_addr),
        .wr_data_i (c_wr_data)
    );

    always #CLK_HALF clk = ~clk;

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first failing check");
    endtask

    function automatic logic [COEFF_W-1:0] rand_coeff();
        logic [31:0] r;
        r = $random(seed);
        return COEFF_W'(r % 32'(DILITHIUM_Q));
    endfunction

    // Plain 64-bit arithmetic mod q
    function automatic logic [COEFF_W-1:0] ref_coeff(input pwo_mode_e m, input logic acc,
                                                     input logic [COEFF_W-1:0] a,
                                                     input logic [COEFF_W-1:0] b,
                                                     input logic [COEFF_W-1:0] c);
        logic [63:0] q;
        logic [63:0] r;
        q = 64'(DILITHIUM_Q);
        case (m)
            MODE_PWA: r = (64'(a) + 64'(b)) % q;
            MODE_PWS: r = (64'(a) + q - 64'(b)) % q;
            default:  r = (64'(a) * 64'(b) + (acc ? 64'(c) : 64'd0)) % q;
        endcase
        return COEFF_W'(r);
    endfunction

    // Load operands, start one run and wait for done
    task automatic run_op(input pwo_mode_e m, input logic acc, input logic stall);
        logic [MEM_ADDR_W-1:0] ba;
        logic [MEM_ADDR_W-1:0] bb;
        logic [MEM_ADDR_W-1:0] bc;
        logic [COEFF_W-1:0]    ca;
        logic [COEFF_W-1:0]    cb;
        logic [COEFF_W-1:0]    cc;
        ba = MEM_ADDR_W'($random(seed));
        bb = MEM_ADDR_W'($random(seed));
        bc = MEM_ADDR_W'($random(seed));
        for (int w = 0; w < WORDS_PER_POLY; w++) begin
            @(posedge clk);
            #1;
            ld_en     = 1'b1;
            ld_addr_a = ba + MEM_ADDR_W'(w);
            ld_addr_b = bb + MEM_ADDR_W'(w);
            ld_addr_c = bc + MEM_ADDR_W'(w);
            for (int l = 0; l < LANES; l++) begin
                ca = rand_coeff();
                cb = rand_coeff();
                cc = rand_coeff();
                if (w == 0) begin
                    // Wrap and borrow corners in the first word
                    ca = (l == 1) ? '0 : Q_MAX;
                    cb = (l == 2) ? COEFF_W'(1) : Q_MAX;
                    cc = Q_MAX;
                end
                ld_data_a[l*LANE_W +: LANE_W] = {1'b0, ca};
                ld_data_b[l*LANE_W +: LANE_W] = {1'b0, cb};
                ld_data_c[l*LANE_W +: LANE_W] = {1'b0, cc};
                exp_mem[w][l*LANE_W +: LANE_W] = {1'b0, ref_coeff(m, acc, ca, cb, cc)};
            end
        end
        @(posedge clk);
        #1;
        ld_en         = 1'b0;
        run_base_c    = bc;
        stall_run     = stall;
        acc_mult_run  = acc && (m == MODE_PWM);
        mode          = m;
        accumulate    = acc;
        base_a        = ba;
        base_b        = bb;
        base_c        = bc;
        sampler_valid = 1'b1;
        ntt_enable    = 1'b1;
        @(posedge clk);
        #1;
        ntt_enable = 1'b0;
        // Settings are latched at the start so the inputs may move
        mode       = (m == MODE_PWA) ? MODE_PWS : MODE_PWA;
        accumulate = ~acc;
        base_a     = MEM_ADDR_W'($random(seed));
        base_b     = MEM_ADDR_W'($random(seed));
        base_c     = MEM_ADDR_W'($random(seed));
        while (!done_seen) begin
            if (stall) begin
                sampler_valid = ($random(seed) % 3) != 0;
            end
            @(posedge clk);
            #1;
        end
        sampler_valid = 1'b1;
        assert (wr_count == WORDS_PER_POLY)
        else stop_with_failure($sformatf("** Error: write count: got %h, expected %h",
                                         wr_count, WORDS_PER_POLY));
    endtask

    // ======================================================================
    // Checks
    // ======================================================================

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("Error: timeout after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    always @(posedge clk) begin : monitor
        logic [MEM_ADDR_W-1:0] wr_idx;
        logic [WORD_CNT_W-1:0] wr_word;
        if (reset_n) begin
            if (!started) begin
                assert (!a_rd_en && !b_rd_en && !c_rd_en && !wr_en && !done)
                else stop_with_failure("Error: strobe or done high before the first start");
            end
            assert (sampler_valid || !(a_rd_en || b_rd_en || c_rd_en))
            else stop_with_failure("Error: read strobe high while sampler_valid is low");
            assert (b_rd_en == a_rd_en && c_rd_en == (a_rd_en && acc_mult_run))
            else stop_with_failure("Error: read strobes do not match the run mode");

            if (ntt_enable) begin
                started     = 1'b1;
                run_active  = 1'b1;
                done_seen   = 1'b0;
                wr_count    = 0;
                start_cycle = cycle_cnt;
                for (int i = 0; i < WORDS_PER_POLY; i++) begin
                    written[i] = 1'b0;
                end
            end

            if (wr_en) begin
                wr_idx = wr_addr - run_base_c;
                assert (int'(wr_idx) < WORDS_PER_POLY)
                else stop_with_failure($sformatf("** Error: mem_wr_addr_o %h outside c at %h",
                                                 wr_addr, run_base_c));
                wr_word = wr_idx[WORD_CNT_W-1:0];
                assert (!written[wr_word])
                else stop_with_failure($sformatf("Error: word %0d written twice", wr_word));
                assert (wr_data == exp_mem[wr_word])
                else stop_with_failure($sformatf(
                    "** Error: mem_wr_data_o word %0d: got %h, expected %h",
                    wr_word, wr_data, exp_mem[wr_word]));
                written[wr_word] = 1'b1;
                wr_count         = wr_count + 1;
                last_wr_cycle    = cycle_cnt;
            end

            if (done) begin
                assert (run_active)
                else stop_with_failure("Error: ntt_done_o high with no run in progress");
                assert (cycle_cnt == last_wr_cycle + 1)
                else stop_with_failure($sformatf("** Error: ntt_done_o cycle: got %h, expected %h",
                                                 cycle_cnt, last_wr_cycle + 1));
                if (!stall_run) begin
                    assert (cycle_cnt - start_cycle + 1 == RUN_CYCLES)
                    else stop_with_failure($sformatf(
                        "** Error: ntt_done_o run length: got %h, expected %h",
                        cycle_cnt - start_cycle + 1, RUN_CYCLES));
                end
                run_active = 1'b0;
                done_seen  = 1'b1;
            end
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================

    initial begin
        reset_n       = 1'b0;
        zeroize       = 1'b0;
        mode          = MODE_PWM;
        ntt_enable    = 1'b0;
        accumulate    = 1'b0;
        sampler_valid = 1'b0;
        base_a        = '0;
        base_b        = '0;
        base_c        = '0;
        ld_en         = 1'b0;
        ld_addr_a     = '0;
        ld_addr_b     = '0;
        ld_addr_c     = '0;
        ld_data_a     = '0;
        ld_data_b     = '0;
        ld_data_c     = '0;
        run_base_c    = '0;
        stall_run     = 1'b0;
        acc_mult_run  = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;
        // Idle window before any start
        repeat (4) @(posedge clk);

        run_op(MODE_PWA, 1'b0, 1'b0);
        run_op(MODE_PWS, 1'b0, 1'b0);
        run_op(MODE_PWM, 1'b0, 1'b0);
        run_op(MODE_PWM, 1'b1, 1'b0);

        // Sampler back-pressure
        run_op(MODE_PWA, 1'b0, 1'b1);
        run_op(MODE_PWS, 1'b0, 1'b1);
        run_op(MODE_PWM, 1'b1, 1'b1);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/ntt_defines_pkg.sv
rtl/pwo_mod_mult.sv
rtl/pwo_lane.sv
rtl/pwo_unit.sv
rtl/ntt_ctrl.sv
rtl/ntt_top.sv
testbench/pwo_mem_model.sv
testbench/ntt_top_tb.sv

/* Makefile */
VERILATOR  := verilator
FILELIST   := sim.f
TOP        := ntt_top_tb
RTL_TOP    := ntt_top
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

# RTL top level only
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# Exit status of the binary is the test result
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
